//--- list.f
+incdir+testbench
source/rnn_pkg.sv
source/coef_ram.sv
source/mac_unit.sv
source/activation_unit.sv
source/layer_sequencer.sv
source/rnn_gain_top.sv
testbench/tb_rnn_gain.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
# the activation unit loads its table from the working directory
cp source/tanh_table.mem tanh_table.mem
verilator --binary --timing -Wno-fatal --top-module tb_rnn_gain -f list.f -o sim_rnn_gain
./obj_dir/sim_rnn_gain > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log; then
	exit 1
fi
if ! grep -q "No errors" sim.log; then
	exit 1
fi

//--- source/activation_unit.sv
`timescale 1ns/10ps
`default_nettype none

module activation_unit
	import rnn_pkg::*;
(
	input  logic  clk,
	input  func_t func_i,
	input  act_t  x_i,
	input  act_t  z_i,
	input  act_t  s_i,
	output act_t  y_o
);

	act_t tanh_mem [TANH_ENTRIES];

	act_t arg;
	logic [15:0] mag;
	act_t ent_q;
	act_t arg_q;
	act_t z_q;
	act_t s_q;
	func_t func_q;
	logic sat_q;
	act_t th;
	act_t sg;
	act_t cand;
	logic signed [31:0] zs;
	logic signed [31:0] zc;

	// entries hold tanh(k/16) for k = 0..63
	initial begin
		$readmemh(TANH_FILE, tanh_mem);
	end

	// sigmoid(x) = tanh(x/2)/2 + 1/2
	assign arg = (func_i == FUNC_SIGM) ? (x_i >>> 1) : x_i;
	assign mag = arg[15] ? -arg : arg;

	always_ff @(posedge clk) begin
		ent_q <= tanh_mem[mag[9:4]];
		sat_q <= |mag[15:10];
		arg_q <= arg;
		func_q <= func_i;
		z_q <= z_i;
		s_q <= s_i;
	end

	// |x| >= 4.0 clamps to +-1
	always_comb begin
		if (sat_q) begin
			th = arg_q[15] ? MINUS_ONE_Q : ONE_Q;
		end else begin
			th = arg_q[15] ? -ent_q : ent_q;
		end
	end

	assign sg = (th >>> 1) + HALF_Q;
	assign cand = arg_q[15] ? '0 : arg_q;

	// h = z*s + (1-z)*c
	assign zs = z_q * s_q;
	assign zc = (ONE_Q - z_q) * cand;

	always_comb begin
		case (func_q)
			FUNC_TANH: y_o = th;
			FUNC_SIGM: y_o = sg;
			FUNC_RELU: y_o = cand;
			FUNC_GRU: y_o = zs[23:8] + zc[23:8];
			default: y_o = s_q;
		endcase
	end

endmodule

`default_nettype wire

//--- source/coef_ram.sv
`timescale 1ns/10ps
`default_nettype none

module coef_ram #(
	parameter type word_t = logic [15:0],
	parameter int DEPTH = 32
) (
	input  logic                     clk,
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  word_t                    wdata_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_a_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_b_i,
	output word_t                    rdata_a_o,
	output word_t                    rdata_b_o
);

	word_t mem [DEPTH];

	// write first in program order, reads return the old word on a collision
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_a_o <= mem[raddr_a_i];
		rdata_b_o <= mem[raddr_b_i];
	end

endmodule

`default_nettype wire

//--- source/layer_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module layer_sequencer
	import rnn_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      feat_valid_i,
	input  logic      gain_ready_i,
	output logic      feat_ready_o,
	output logic      gain_valid_o,
	output wt_addr_t  wt_raddr_o,
	output act_addr_t act_raddr_a_o,
	output act_addr_t act_raddr_b_o,
	output act_addr_t act_waddr_o,
	output logic      act_we_o,
	output logic      act_wsel_o,
	output logic      mac_clear_o,
	output logic      mac_en_o,
	output logic      mac_bias_o,
	output logic      mac_gate_o,
	output func_t     act_func_o
);

	typedef enum logic [2:0] {
		S_CLR, S_IN, S_DENSE, S_GRU1, S_GRU2, S_COPY, S_OUT, S_GAINS
	} state_t;
	typedef enum logic [1:0] {PH_BIAS, PH_IN, PH_REC, PH_ACT} phase_t;

	state_t state_q;
	phase_t phase_q;
	cnt_t nrn_q;
	cnt_t in_q;
	cnt_t rec_q;
	logic gain_vld_q;

	cnt_t n_last;
	cnt_t m_last;
	logic has_rec;
	wt_addr_t w_base;
	wt_addr_t b_base;
	wt_addr_t stride;
	wt_addr_t col;
	act_addr_t in_base;
	act_addr_t out_base;
	func_t func;

	logic compute;
	logic iss_act;
	logic feat_fire;
	logic gain_fire;
	logic we_d1;
	logic we_d2;
	act_addr_t waddr_d1;
	act_addr_t waddr_d2;

	// layer shape, defaults describe the recurrent layer
	always_comb begin
		n_last = cnt_t'(GRU_SIZE - 1);
		m_last = cnt_t'(DENSE_SIZE - 1);
		has_rec = 1'b0;
		w_base = GRU_W_BASE;
		b_base = GRU_B_BASE;
		stride = wt_addr_t'(3 * GRU_SIZE);
		col = wt_addr_t'(nrn_q);
		in_base = ACT_DENSE;
		out_base = ACT_STATE;
		func = FUNC_RELU;
		case (state_q)
			S_DENSE: begin
				n_last = cnt_t'(DENSE_SIZE - 1);
				m_last = cnt_t'(FEATURE_SIZE - 1);
				w_base = DENSE_W_BASE;
				b_base = DENSE_B_BASE;
				stride = wt_addr_t'(DENSE_SIZE);
				in_base = ACT_FEAT;
				out_base = ACT_DENSE;
				func = FUNC_TANH;
			end
			S_GRU1: begin
				// z and r gates run as one row, written to ZGATE then RGATE
				n_last = cnt_t'(2 * GRU_SIZE - 1);
				has_rec = 1'b1;
				out_base = ACT_ZGATE;
				func = FUNC_SIGM;
			end
			S_GRU2: begin
				has_rec = 1'b1;
				col = wt_addr_t'(nrn_q) + wt_addr_t'(2 * GRU_SIZE);
				out_base = ACT_HNEW;
				func = FUNC_GRU;
			end
			S_COPY: begin
				func = FUNC_COPY;
			end
			S_OUT: begin
				n_last = cnt_t'(GAIN_SIZE - 1);
				m_last = cnt_t'(GRU_SIZE - 1);
				w_base = OUT_W_BASE;
				b_base = OUT_B_BASE;
				stride = wt_addr_t'(GAIN_SIZE);
				in_base = ACT_STATE;
				out_base = ACT_GAIN;
				func = FUNC_SIGM;
			end
			default: begin
			end
		endcase
	end

	assign compute = (state_q == S_DENSE) || (state_q == S_GRU1) ||
		(state_q == S_GRU2) || (state_q == S_OUT);
	assign iss_act = (compute && (phase_q == PH_ACT)) || (state_q == S_CLR) ||
		(state_q == S_COPY);

	// hold off input while result writes are still in flight
	assign feat_ready_o = (state_q == S_IN) && !we_d1 && !we_d2;
	assign feat_fire = feat_valid_i && feat_ready_o;
	assign gain_valid_o = gain_vld_q;
	assign gain_fire = gain_vld_q && gain_ready_i;

	always_comb begin
		wt_raddr_o = b_base + col;
		act_raddr_a_o = in_base + act_addr_t'(in_q);
		act_raddr_b_o = ACT_RGATE + act_addr_t'(rec_q);
		case (phase_q)
			PH_IN: begin
				wt_raddr_o = w_base + wt_addr_t'(in_q) * stride + col;
			end
			PH_REC: begin
				wt_raddr_o = GRU_U_BASE + wt_addr_t'(rec_q) * stride + col;
				act_raddr_a_o = ACT_STATE + act_addr_t'(rec_q);
			end
			PH_ACT: begin
				// z and old state for the combine
				act_raddr_a_o = ACT_ZGATE + act_addr_t'(nrn_q);
				act_raddr_b_o = ACT_STATE + act_addr_t'(nrn_q);
			end
			default: begin
			end
		endcase
		if (state_q == S_COPY) begin
			act_raddr_b_o = ACT_HNEW + act_addr_t'(nrn_q);
		end
		if (state_q == S_GAINS) begin
			act_raddr_b_o = ACT_GAIN + act_addr_t'(nrn_q);
		end
	end

	// mac and activation inputs follow the read by one cycle, the write by two
	always_ff @(posedge clk) begin
		if (rst) begin
			mac_clear_o <= 1'b0;
			mac_en_o <= 1'b0;
			mac_bias_o <= 1'b0;
			mac_gate_o <= 1'b0;
			we_d1 <= 1'b0;
			we_d2 <= 1'b0;
		end else begin
			mac_clear_o <= (state_q == S_CLR);
			mac_en_o <= compute && ((phase_q == PH_IN) || (phase_q == PH_REC));
			mac_bias_o <= compute && (phase_q == PH_BIAS);
			mac_gate_o <= (state_q == S_GRU2) && (phase_q == PH_REC);
			we_d1 <= iss_act;
			we_d2 <= we_d1;
		end
	end

	always_ff @(posedge clk) begin
		act_func_o <= func;
		waddr_d1 <= out_base + act_addr_t'(nrn_q);
		waddr_d2 <= waddr_d1;
	end

	assign act_we_o = we_d2 || feat_fire;
	assign act_wsel_o = we_d2;
	assign act_waddr_o = we_d2 ? waddr_d2 : ACT_FEAT + act_addr_t'(in_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_CLR;
			phase_q <= PH_BIAS;
			nrn_q <= '0;
			in_q <= '0;
			rec_q <= '0;
			gain_vld_q <= 1'b0;
		end else begin
			case (state_q)
				S_CLR, S_COPY: begin
					if (nrn_q == cnt_t'(GRU_SIZE - 1)) begin
						nrn_q <= '0;
						state_q <= (state_q == S_CLR) ? S_IN : S_OUT;
					end else begin
						nrn_q <= nrn_q + 1'b1;
					end
				end
				S_IN: begin
					if (feat_fire) begin
						if (in_q == cnt_t'(FEATURE_SIZE - 1)) begin
							in_q <= '0;
							state_q <= S_DENSE;
						end else begin
							in_q <= in_q + 1'b1;
						end
					end
				end
				S_GAINS: begin
					// address settles one cycle before valid rises
					if (gain_fire) begin
						gain_vld_q <= 1'b0;
						if (nrn_q == cnt_t'(GAIN_SIZE - 1)) begin
							nrn_q <= '0;
							state_q <= S_IN;
						end else begin
							nrn_q <= nrn_q + 1'b1;
						end
					end else begin
						gain_vld_q <= 1'b1;
					end
				end
				default: begin
					case (phase_q)
						PH_BIAS: begin
							phase_q <= PH_IN;
						end
						PH_IN: begin
							if (in_q == m_last) begin
								in_q <= '0;
								phase_q <= has_rec ? PH_REC : PH_ACT;
							end else begin
								in_q <= in_q + 1'b1;
							end
						end
						PH_REC: begin
							if (rec_q == cnt_t'(GRU_SIZE - 1)) begin
								rec_q <= '0;
								phase_q <= PH_ACT;
							end else begin
								rec_q <= rec_q + 1'b1;
							end
						end
						PH_ACT: begin
							phase_q <= PH_BIAS;
							if (nrn_q == n_last) begin
								nrn_q <= '0;
								case (state_q)
									S_DENSE: state_q <= S_GRU1;
									S_GRU1: state_q <= S_GRU2;
									S_GRU2: state_q <= S_COPY;
									default: state_q <= S_GAINS;
								endcase
							end else begin
								nrn_q <= nrn_q + 1'b1;
							end
						end
					endcase
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/mac_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mac_unit
	import rnn_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  clear_i,
	input  logic  en_i,
	input  logic  bias_i,
	input  logic  gate_i,
	input  coef_t coef_i,
	input  act_t  x_i,
	input  act_t  g_i,
	output act_t  acc_o
);

	act_t w_ext;
	act_t p1;
	act_t term;
	logic signed [31:0] prod;
	logic signed [31:0] gprod;

	assign w_ext = {{8{coef_i[7]}}, coef_i};
	assign prod = w_ext * x_i;
	assign p1 = prod[23:8];

	// candidate recurrent terms get scaled again by r
	assign gprod = p1 * g_i;
	assign term = gate_i ? gprod[23:8] : p1;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_o <= '0;
		end else if (clear_i) begin
			acc_o <= '0;
		end else if (bias_i) begin
			acc_o <= w_ext;
		end else if (en_i) begin
			acc_o <= acc_o + term;
		end
	end

endmodule

`default_nettype wire

//--- source/rnn_gain_top.sv
`timescale 1ns/10ps
`default_nettype none

module rnn_gain_top
	import rnn_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     wt_we_i,
	input  wt_addr_t wt_addr_i,
	input  coef_t    wt_data_i,
	input  logic     feat_valid_i,
	input  act_t     feat_data_i,
	output logic     feat_ready_o,
	output logic     gain_valid_o,
	output act_t     gain_data_o,
	input  logic     gain_ready_i
);

	wt_addr_t wt_raddr;
	coef_t wt_rdata;
	act_addr_t act_raddr_a;
	act_addr_t act_raddr_b;
	act_addr_t act_waddr;
	logic act_we;
	logic act_wsel;
	act_t act_wdata;
	act_t act_rdata_a;
	act_t act_rdata_b;
	logic mac_clear;
	logic mac_en;
	logic mac_bias;
	logic mac_gate;
	func_t act_func;
	act_t acc;
	act_t act_y;

	layer_sequencer layer_sequencer_inst (
		.clk(clk), .rst(rst),
		.feat_valid_i(feat_valid_i), .gain_ready_i(gain_ready_i),
		.feat_ready_o(feat_ready_o), .gain_valid_o(gain_valid_o),
		.wt_raddr_o(wt_raddr),
		.act_raddr_a_o(act_raddr_a), .act_raddr_b_o(act_raddr_b),
		.act_waddr_o(act_waddr), .act_we_o(act_we), .act_wsel_o(act_wsel),
		.mac_clear_o(mac_clear), .mac_en_o(mac_en),
		.mac_bias_o(mac_bias), .mac_gate_o(mac_gate),
		.act_func_o(act_func)
	);

	// weights only use the first read port
	coef_ram #(.word_t(coef_t), .DEPTH(2 ** WT_ADDR_BITS)) wt_ram_inst (
		.clk(clk), .we_i(wt_we_i), .waddr_i(wt_addr_i), .wdata_i(wt_data_i),
		.raddr_a_i(wt_raddr), .raddr_b_i(wt_raddr),
		.rdata_a_o(wt_rdata), .rdata_b_o()
	);

	// features during input, activation results during compute
	assign act_wdata = act_wsel ? act_y : feat_data_i;

	coef_ram #(.word_t(act_t), .DEPTH(2 ** ACT_ADDR_BITS)) act_ram_inst (
		.clk(clk), .we_i(act_we), .waddr_i(act_waddr), .wdata_i(act_wdata),
		.raddr_a_i(act_raddr_a), .raddr_b_i(act_raddr_b),
		.rdata_a_o(act_rdata_a), .rdata_b_o(act_rdata_b)
	);

	mac_unit mac_unit_inst (
		.clk(clk), .rst(rst),
		.clear_i(mac_clear), .en_i(mac_en), .bias_i(mac_bias), .gate_i(mac_gate),
		.coef_i(wt_rdata), .x_i(act_rdata_a), .g_i(act_rdata_b),
		.acc_o(acc)
	);

	activation_unit activation_unit_inst (
		.clk(clk), .func_i(act_func),
		.x_i(acc), .z_i(act_rdata_a), .s_i(act_rdata_b),
		.y_o(act_y)
	);

	assign gain_data_o = act_rdata_b;

endmodule

`default_nettype wire

//--- source/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

	// layer widths
	localparam int FEATURE_SIZE = 4;
	localparam int DENSE_SIZE = 4;
	localparam int GRU_SIZE = 4;
	localparam int GAIN_SIZE = 2;

	// Q8.8 activations, weights read as Q8.8 after sign extension
	typedef logic signed [15:0] act_t;
	typedef logic signed [7:0] coef_t;

	localparam int WT_ADDR_BITS = 8;
	localparam int ACT_ADDR_BITS = 5;
	typedef logic [WT_ADDR_BITS-1:0] wt_addr_t;
	typedef logic [ACT_ADDR_BITS-1:0] act_addr_t;
	typedef logic [2:0] cnt_t;
	typedef logic [2:0] func_t;

	// weight from input k to neuron j sits at base + k * stride + j
	// recurrent gates at column offsets 0 (z), GRU_SIZE (r), 2*GRU_SIZE (candidate)
	localparam wt_addr_t DENSE_W_BASE = '0;
	localparam wt_addr_t DENSE_B_BASE = DENSE_W_BASE + wt_addr_t'(FEATURE_SIZE * DENSE_SIZE);
	localparam wt_addr_t GRU_W_BASE = DENSE_B_BASE + wt_addr_t'(DENSE_SIZE);
	localparam wt_addr_t GRU_U_BASE = GRU_W_BASE + wt_addr_t'(DENSE_SIZE * 3 * GRU_SIZE);
	localparam wt_addr_t GRU_B_BASE = GRU_U_BASE + wt_addr_t'(GRU_SIZE * 3 * GRU_SIZE);
	localparam wt_addr_t OUT_W_BASE = GRU_B_BASE + wt_addr_t'(3 * GRU_SIZE);
	localparam wt_addr_t OUT_B_BASE = OUT_W_BASE + wt_addr_t'(GRU_SIZE * GAIN_SIZE);

	// activation memory regions
	localparam act_addr_t ACT_FEAT = '0;
	localparam act_addr_t ACT_DENSE = ACT_FEAT + act_addr_t'(FEATURE_SIZE);
	localparam act_addr_t ACT_STATE = ACT_DENSE + act_addr_t'(DENSE_SIZE);
	localparam act_addr_t ACT_ZGATE = ACT_STATE + act_addr_t'(GRU_SIZE);
	localparam act_addr_t ACT_RGATE = ACT_ZGATE + act_addr_t'(GRU_SIZE);
	localparam act_addr_t ACT_HNEW = ACT_RGATE + act_addr_t'(GRU_SIZE);
	localparam act_addr_t ACT_GAIN = ACT_HNEW + act_addr_t'(GRU_SIZE);

	localparam act_t ONE_Q = 16'sh0100;
	localparam act_t HALF_Q = 16'sh0080;
	localparam act_t MINUS_ONE_Q = -16'sh0100;

	// activation function select
	localparam func_t FUNC_TANH = 3'd0;
	localparam func_t FUNC_SIGM = 3'd1;
	localparam func_t FUNC_RELU = 3'd2;
	localparam func_t FUNC_GRU = 3'd3;
	localparam func_t FUNC_COPY = 3'd4;

	localparam int TANH_ENTRIES = 64;
	localparam string TANH_FILE = "tanh_table.mem";

endpackage

`default_nettype wire

//--- source/tanh_table.mem
// tanh(k/16) in Q8.8, one entry per line for k = 0..63
0000
0010
0020
002F
003F
004D
005C
0069
0076
0083
008E
0099
00A3
00AC
00B4
00BC
00C3
00C9
00CF
00D5
00D9
00DD
00E1
00E5
00E8
00EA
00ED
00EF
00F1
00F3
00F4
00F6
00F7
00F8
00F9
00FA
00FA
00FB
00FC
00FC
00FD
00FD
00FD
00FE
00FE
00FE
00FE
00FF
00FF
00FF
00FF
00FF
00FF
00FF
00FF
00FF
0100
0100
0100
0100
0100
0100
0100
0100

//--- testbench/rnn_ref_model.svh
`ifndef RNN_REF_MODEL_SVH
`define RNN_REF_MODEL_SVH

// testbench copies of the weights, the recurrent state and the tanh table
coef_t wt_ref [2**WT_ADDR_BITS];
act_t state_ref [GRU_SIZE];
act_t tanh_ref [TANH_ENTRIES];

// Q8.8 product, bits 23:8 of the full product
function automatic act_t qmul(act_t a, act_t b);
	int p;
	p = int'(a) * int'(b);
	return p[23:8];
endfunction

function automatic act_t wq(int addr);
	act_t v;
	v = wt_ref[addr];
	return v;
endfunction

function automatic act_t tanh_q(act_t x);
	int m;
	m = (x < 0) ? -int'(x) : int'(x);
	if (m >= 1024) begin
		return (x < 0) ? -16'sd256 : 16'sd256;
	end
	return (x < 0) ? -tanh_ref[m >> 4] : tanh_ref[m >> 4];
endfunction

function automatic act_t sigm_q(act_t x);
	act_t t;
	t = tanh_q(x >>> 1);
	return (t >>> 1) + 16'sd128;
endfunction

function automatic act_t relu_q(act_t x);
	return (x < 0) ? 16'sd0 : x;
endfunction

// one frame through all layers, the state moves on to the next frame
function automatic void ref_frame(input act_t f [FEATURE_SIZE], output act_t g [GAIN_SIZE]);
	act_t dense [DENSE_SIZE];
	act_t gate [2*GRU_SIZE];
	act_t hnew [GRU_SIZE];
	act_t acc;
	int stride;
	stride = 3 * GRU_SIZE;
	for (int j = 0; j < DENSE_SIZE; j++) begin
		acc = wq(DENSE_B_BASE + j);
		for (int k = 0; k < FEATURE_SIZE; k++) begin
			acc = acc + qmul(wq(DENSE_W_BASE + k * DENSE_SIZE + j), f[k]);
		end
		dense[j] = tanh_q(acc);
	end
	// z gates then r gates
	for (int j = 0; j < 2 * GRU_SIZE; j++) begin
		acc = wq(GRU_B_BASE + j);
		for (int k = 0; k < DENSE_SIZE; k++) begin
			acc = acc + qmul(wq(GRU_W_BASE + k * stride + j), dense[k]);
		end
		for (int k = 0; k < GRU_SIZE; k++) begin
			acc = acc + qmul(wq(GRU_U_BASE + k * stride + j), state_ref[k]);
		end
		gate[j] = sigm_q(acc);
	end
	for (int j = 0; j < GRU_SIZE; j++) begin
		acc = wq(GRU_B_BASE + 2 * GRU_SIZE + j);
		for (int k = 0; k < DENSE_SIZE; k++) begin
			acc = acc + qmul(wq(GRU_W_BASE + k * stride + 2 * GRU_SIZE + j), dense[k]);
		end
		for (int k = 0; k < GRU_SIZE; k++) begin
			acc = acc + qmul(qmul(wq(GRU_U_BASE + k * stride + 2 * GRU_SIZE + j),
				state_ref[k]), gate[GRU_SIZE + k]);
		end
		hnew[j] = qmul(gate[j], state_ref[j]) + qmul(16'sd256 - gate[j], relu_q(acc));
	end
	for (int j = 0; j < GRU_SIZE; j++) begin
		state_ref[j] = hnew[j];
	end
	for (int j = 0; j < GAIN_SIZE; j++) begin
		acc = wq(OUT_B_BASE + j);
		for (int k = 0; k < GRU_SIZE; k++) begin
			acc = acc + qmul(wq(OUT_W_BASE + k * GAIN_SIZE + j), state_ref[k]);
		end
		g[j] = sigm_q(acc);
	end
endfunction

`endif

//--- testbench/tb_rnn_gain.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rnn_gain
	import rnn_pkg::*;
();

	localparam int N_FRAMES = 17;
	localparam int CYCLE_LIMIT = N_FRAMES * 400 + 1000;
	localparam int N_WEIGHTS = int'(OUT_B_BASE) + GAIN_SIZE;

	logic clk;
	logic rst;
	logic wt_we_i;
	wt_addr_t wt_addr_i;
	coef_t wt_data_i;
	logic feat_valid_i;
	act_t feat_data_i;
	logic feat_ready_o;
	logic gain_valid_o;
	act_t gain_data_o;
	logic gain_ready_i;

	act_t exp_q [$];
	string test_name;
	int cycles;
	int feat_cnt;
	int gain_cnt;
	logic busy;
	int err_count;
	logic stall;
	coef_t wt_saved [2**WT_ADDR_BITS];
	act_t first_feat [FEATURE_SIZE];
	act_t feat [FEATURE_SIZE];

	`include "rnn_ref_model.svh"

	rnn_gain_top rnn_gain_top_inst (
		.clk(clk), .rst(rst),
		.wt_we_i(wt_we_i), .wt_addr_i(wt_addr_i), .wt_data_i(wt_data_i),
		.feat_valid_i(feat_valid_i), .feat_data_i(feat_data_i), .feat_ready_o(feat_ready_o),
		.gain_valid_o(gain_valid_o), .gain_data_o(gain_data_o), .gain_ready_i(gain_ready_i)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input int expv, input int actv);
		if (expv != actv) begin
			err_count++;
			$display("[ERROR] %s expected %0d actual %0d", name, expv, actv);
			$display("Errors found");
			$fatal(1, "check failed");
		end
	endtask

	// gain compare and handshake checks
	always @(posedge clk) begin
		if (rst) begin
			feat_cnt = 0;
			gain_cnt = 0;
			busy = 1'b0;
		end else begin
			if (busy) begin
				check_value({test_name, " feat_ready low"}, 0, int'(feat_ready_o));
			end
			if (feat_valid_i && feat_ready_o) begin
				feat_cnt++;
				if (feat_cnt == FEATURE_SIZE) begin
					feat_cnt = 0;
					busy = 1'b1;
				end
			end
			if (gain_valid_o && gain_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("a gain was sent while no frame was pending");
					$display("Errors found");
					$fatal(1, "unexpected gain");
				end
				check_value(test_name, exp_q[0], gain_data_o);
				check_value({test_name, " gain in range"}, 1,
					int'(gain_data_o >= 0 && gain_data_o <= ONE_Q));
				void'(exp_q.pop_front());
				// input reopens only after the frame's last gain
				gain_cnt++;
				if (gain_cnt == GAIN_SIZE) begin
					gain_cnt = 0;
					busy = 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

	// random stalls on the gain stream
	always @(negedge clk) begin
		gain_ready_i = stall ? 1'($urandom_range(0, 1)) : 1'b1;
	end

	task automatic gen_weights(input int extreme);
		for (int a = 0; a < N_WEIGHTS; a++) begin
			if (extreme != 0) begin
				wt_ref[a] = $urandom_range(0, 1) ? 8'sd127 : -8'sd128;
			end else begin
				wt_ref[a] = coef_t'($urandom_range(0, 63) - 32);
			end
		end
	endtask

	task automatic write_weights();
		@(negedge clk);
		while (!feat_ready_o) @(negedge clk);
		for (int a = 0; a < N_WEIGHTS; a++) begin
			wt_we_i = 1'b1;
			wt_addr_i = wt_addr_t'(a);
			wt_data_i = wt_ref[a];
			@(negedge clk);
		end
		wt_we_i = 1'b0;
	endtask

	task automatic fill_frame(input int extreme);
		for (int k = 0; k < FEATURE_SIZE; k++) begin
			if (extreme != 0) begin
				feat[k] = $urandom_range(0, 1) ? 16'sh7fff : 16'sh8000;
			end else begin
				feat[k] = act_t'($urandom_range(0, 1023) - 512);
			end
		end
	endtask

	task automatic send_frame(input act_t f [FEATURE_SIZE]);
		act_t g [GAIN_SIZE];
		ref_frame(f, g);
		for (int j = 0; j < GAIN_SIZE; j++) begin
			exp_q.push_back(g[j]);
		end
		for (int k = 0; k < FEATURE_SIZE; k++) begin
			@(negedge clk);
			feat_valid_i = 1'b1;
			feat_data_i = f[k];
			while (!feat_ready_o) @(negedge clk);
		end
		@(negedge clk);
		feat_valid_i = 1'b0;
	endtask

	task automatic wait_gains();
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	initial begin
		void'($urandom(11));
		clk = 1'b0;
		rst = 1'b1;
		wt_we_i = 1'b0;
		wt_addr_i = '0;
		wt_data_i = '0;
		feat_valid_i = 1'b0;
		feat_data_i = '0;
		gain_ready_i = 1'b1;
		stall = 1'b0;
		cycles = 0;
		err_count = 0;
		test_name = "single frame";
		$readmemh("source/tanh_table.mem", tanh_ref);
		for (int j = 0; j < GRU_SIZE; j++) begin
			state_ref[j] = '0;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;

		gen_weights(0);
		wt_saved = wt_ref;
		write_weights();
		fill_frame(0);
		first_feat = feat;
		send_frame(feat);
		wait_gains();

		test_name = "recurrent state";
		repeat (8) begin
			fill_frame(0);
			send_frame(feat);
			wait_gains();
		end

		test_name = "saturation";
		gen_weights(1);
		write_weights();
		repeat (2) begin
			fill_frame(1);
			send_frame(feat);
			wait_gains();
		end

		// frames go in back to back while gains stall
		test_name = "back-pressure";
		stall = 1'b1;
		repeat (4) begin
			fill_frame(0);
			send_frame(feat);
		end
		wait_gains();
		stall = 1'b0;

		test_name = "reset";
		fill_frame(0);
		send_frame(feat);
		repeat (30) @(negedge clk);
		rst = 1'b1;
		exp_q.delete();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		for (int j = 0; j < GRU_SIZE; j++) begin
			state_ref[j] = '0;
		end
		wt_ref = wt_saved;
		write_weights();
		send_frame(first_feat);
		wait_gains();

		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
